//--- UProcPkg.sv
// Shared widths, SPI command, mapped-register map and control word of the boot subsystem.
package UProcPkg;

	//--------------------------------------------------------------------------
	// Bus widths and storage protocol.
	//--------------------------------------------------------------------------

	// SRAM address and data word width.
	localparam int MEM_W = 16;

	// EEPROM read command, followed by a 16-bit start address.
	localparam logic [7:0] SPI_READ_CMD = 8'h03;

	//--------------------------------------------------------------------------
	// Mapped-register window.
	//--------------------------------------------------------------------------

	// Bit 15 set selects the mapped window instead of SRAM.
	localparam logic [MEM_W-1:0] MAP_BASE      = 16'h8000;
	localparam logic [MEM_W-1:0] MAP_CTRL_ADDR = 16'h8000;
	localparam logic [MEM_W-1:0] MAP_STAT_ADDR = 16'h8001;

	// Status word layout.
	localparam int STAT_BOOTED_BIT = 0;
	localparam int STAT_PAUSED_BIT = 1;
	localparam int STAT_COUNT_LSB  = 8;
	localparam int STAT_COUNT_MSB  = 15;

	// Control word, raw on the bus or split into fields.
	typedef union packed {
		logic [MEM_W-1:0] raw;
		struct packed {
			logic [7:0] tag;
			logic [6:0] rsvd;
			logic       pauseReq;
		} f;
	} ctrlWord_u;

endpackage

//--- SysControl.sv
// System control: reset and pause-pin synchronizers plus the pause network registers.
`timescale 1ns/1ps

module SysControl (
	input  logic i_sysClk,
	input  logic i_arstN,
	input  logic i_smDoPause,
	input  logic i_pauseReq,
	input  logic i_nowBooted,
	output logic o_rstN,
	output logic o_isPaused
);

	// Reset synchronizer chain.
	logic [1:0] rstSync;
	// Pause pin synchronizer chain.
	logic [1:0] pauseSync;
	// Pause network registers.
	logic       startPause;
	logic       isPaused;

	//--------------------------------------------------------------------------
	// Reset synchronizer.
	//--------------------------------------------------------------------------

	// Assert at once, release after two clocks.
	always_ff @(posedge i_sysClk or negedge i_arstN) begin
		if (!i_arstN) begin
			rstSync <= 2'b00;
		end else begin
			rstSync <= {rstSync[0], 1'b1};
		end
	end

	assign o_rstN = rstSync[1];

	//--------------------------------------------------------------------------
	// Pause pin synchronizer and pause network.
	//--------------------------------------------------------------------------

	always_ff @(posedge i_sysClk or negedge o_rstN) begin
		if (!o_rstN) begin
			pauseSync  <= 2'b00;
			startPause <= 1'b0;
			isPaused   <= 1'b0;
		end else begin
			pauseSync  <= {pauseSync[0], i_smDoPause};
			// Pin or control bit requests a pause.
			startPause <= pauseSync[1] | i_pauseReq;
			// Only a booted chip is formally paused.
			isPaused   <= startPause & i_nowBooted;
		end
	end

	// Drops one cycle after the request goes away.
	assign o_isPaused = isPaused;

endmodule

//--- BootImage.sv
// Bootloader: SPI master that streams the program image from EEPROM into SRAM.
`timescale 1ns/1ps

module BootImage #(
	parameter int SPI_HALF_DIV = 2
) (
	input  logic                       i_sysClk,
	input  logic                       i_rstN,
	input  logic                       i_spiMISO,
	output logic                       o_spiCLK,
	output logic                       o_spiMOSI,
	output logic                       o_spiCSn,
	output logic [UProcPkg::MEM_W-1:0] o_memAddr,
	output logic [UProcPkg::MEM_W-1:0] o_memDataOut,
	output logic                       o_memEn,
	output logic                       o_nowBooted,
	output logic [7:0]                 o_wordCount
);
	import UProcPkg::*;

	// Divider width, at least one bit.
	localparam int DIV_W = (SPI_HALF_DIV > 1) ? $clog2(SPI_HALF_DIV) : 1;

	// Image start address in EEPROM.
	localparam logic [15:0] IMG_ADDR = 16'h0000;

	// FSM states.
	localparam logic [2:0] ST_IDLE  = 3'd0;
	localparam logic [2:0] ST_CMD   = 3'd1;
	localparam logic [2:0] ST_ADDR  = 3'd2;
	localparam logic [2:0] ST_COUNT = 3'd3;
	localparam logic [2:0] ST_DATA  = 3'd4;
	localparam logic [2:0] ST_DONE  = 3'd5;

	logic [2:0]       state;
	logic [DIV_W-1:0] divCnt;
	logic             sck;
	logic             csN;
	logic [3:0]       bitCnt;
	// Command and address, MSB first.
	logic [23:0]      txSr;
	logic [MEM_W-1:0] rxSr;
	logic [MEM_W-1:0] wordTotal;
	logic [MEM_W-1:0] wordIdx;
	logic [MEM_W-1:0] memAddr;
	logic [MEM_W-1:0] memData;
	logic             memEn;
	logic             booted;

	logic             shifting;
	logic             halfTick;
	logic             riseTick;
	logic             fallTick;
	logic             lastBit;
	logic             fieldDone;
	logic             wordDone;

	//--------------------------------------------------------------------------
	// SCK phase timing.
	//--------------------------------------------------------------------------

	assign shifting  = (state == ST_CMD) || (state == ST_ADDR) ||
	                   (state == ST_COUNT) || (state == ST_DATA);
	assign halfTick  = shifting && (divCnt == DIV_W'(SPI_HALF_DIV - 1));
	// Rising edge samples MISO, falling edge moves MOSI.
	assign riseTick  = halfTick & ~sck;
	assign fallTick  = halfTick & sck;
	// Command is 8 bits, all other fields 16.
	assign lastBit   = (state == ST_CMD) ? (bitCnt == 4'd7) : (bitCnt == 4'd15);
	assign fieldDone = fallTick & lastBit;
	assign wordDone  = fieldDone & (state == ST_DATA);

	//--------------------------------------------------------------------------
	// Sequencer.
	//--------------------------------------------------------------------------

	always_ff @(posedge i_sysClk or negedge i_rstN) begin
		if (!i_rstN) begin
			state     <= ST_IDLE;
			divCnt    <= '0;
			sck       <= 1'b0;
			csN       <= 1'b1;
			bitCnt    <= '0;
			txSr      <= '0;
			wordTotal <= '0;
			wordIdx   <= '0;
			memEn     <= 1'b0;
			booted    <= 1'b0;
		end else begin
			// Single-cycle write strobe per data word.
			memEn <= wordDone;
			if (state == ST_IDLE) begin
				csN   <= 1'b0;
				txSr  <= {SPI_READ_CMD, IMG_ADDR};
				state <= ST_CMD;
			end
			if (shifting) begin
				if (halfTick) begin
					divCnt <= '0;
					sck    <= ~sck;
				end else begin
					divCnt <= divCnt + 1'b1;
				end
			end
			if (fallTick) begin
				txSr   <= {txSr[22:0], 1'b0};
				bitCnt <= lastBit ? 4'd0 : bitCnt + 1'b1;
			end
			if (fieldDone) begin
				case (state)
					ST_CMD:  state <= ST_ADDR;
					ST_ADDR: state <= ST_COUNT;
					ST_COUNT: begin
						wordTotal <= rxSr;
						// Empty image ends at once.
						if (rxSr == '0) begin
							state <= ST_DONE;
							csN   <= 1'b1;
						end else begin
							state <= ST_DATA;
						end
					end
					ST_DATA: begin
						wordIdx <= wordIdx + 1'b1;
						if (wordIdx == wordTotal - 1'b1) begin
							state <= ST_DONE;
							csN   <= 1'b1;
						end
					end
					default: state <= state;
				endcase
			end
			// Set after the last strobe, held until reset.
			if (state == ST_DONE) begin
				booted <= 1'b1;
			end
		end
	end

	// Receive shifter and SRAM write payload.
	always_ff @(posedge i_sysClk) begin
		if (riseTick) begin
			rxSr <= {rxSr[MEM_W-2:0], i_spiMISO};
		end
		if (wordDone) begin
			memAddr <= wordIdx;
			memData <= rxSr;
		end
	end

	assign o_spiCLK     = sck;
	assign o_spiMOSI    = txSr[23];
	assign o_spiCSn     = csN;
	assign o_memAddr    = memAddr;
	assign o_memDataOut = memData;
	assign o_memEn      = memEn;
	assign o_nowBooted  = booted;
	assign o_wordCount  = wordTotal[7:0];

endmodule

//--- MemController.sv
// SRAM bus arbiter between boot and debug, with mapped window decode and debug ack.
`timescale 1ns/1ps

module MemController (
	input  logic                       i_sysClk,
	input  logic                       i_rstN,
	input  logic [UProcPkg::MEM_W-1:0] i_bootAddr,
	input  logic [UProcPkg::MEM_W-1:0] i_bootData,
	input  logic                       i_bootEn,
	input  logic                       i_dbgEn,
	input  logic                       i_dbgWr,
	input  logic [UProcPkg::MEM_W-1:0] i_dbgAddr,
	input  logic [UProcPkg::MEM_W-1:0] i_dbgWrData,
	input  logic                       i_isBooted,
	input  logic                       i_isPaused,
	input  logic [UProcPkg::MEM_W-1:0] i_mapRdData,
	input  logic [UProcPkg::MEM_W-1:0] i_memDataIn,
	output logic [UProcPkg::MEM_W-1:0] o_dbgRdData,
	output logic                       o_dbgAck,
	output logic                       o_dbgErr,
	output logic [UProcPkg::MEM_W-1:0] o_memAddr,
	output logic [UProcPkg::MEM_W-1:0] o_memDataOut,
	output logic                       o_memWr,
	output logic                       o_memEn,
	output logic                       o_mapAddrSel,
	output logic                       o_mapWrEn,
	output logic [UProcPkg::MEM_W-1:0] o_mapWrData
);
	import UProcPkg::*;

	// Request taken until the host drops i_dbgEn.
	logic             busy;
	// Stage 1 issues the access.
	logic             s1Valid;
	logic             s1Wr;
	logic             s1Map;
	logic             s1Err;
	logic [MEM_W-1:0] s1Addr;
	logic [MEM_W-1:0] s1Data;
	// Stage 2 acks the request.
	logic             ackQ;
	logic             errQ;
	logic             memRdQ;
	logic [MEM_W-1:0] capData;

	logic             reqMap;
	logic             accept;
	logic             dbgMemEn;

	// Requests wait until the boot is complete.
	assign reqMap = |(i_dbgAddr & MAP_BASE);
	assign accept = i_dbgEn & i_isBooted & ~busy;

	//--------------------------------------------------------------------------
	// Debug sequencer.
	//--------------------------------------------------------------------------

	always_ff @(posedge i_sysClk or negedge i_rstN) begin
		if (!i_rstN) begin
			busy    <= 1'b0;
			s1Valid <= 1'b0;
			ackQ    <= 1'b0;
			errQ    <= 1'b0;
			memRdQ  <= 1'b0;
		end else begin
			s1Valid <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (!i_dbgEn && !s1Valid) begin
				busy <= 1'b0;
			end
			ackQ   <= s1Valid;
			errQ   <= s1Valid & s1Err;
			// SRAM data arrives in the ack cycle.
			memRdQ <= s1Valid & ~s1Map & ~s1Err & ~s1Wr;
		end
	end

	// Decode and pause check.
	always_ff @(posedge i_sysClk) begin
		if (accept) begin
			s1Wr   <= i_dbgWr;
			s1Map  <= reqMap;
			// SRAM access only while paused.
			s1Err  <= ~reqMap & ~i_isPaused;
			s1Addr <= i_dbgAddr;
			s1Data <= i_dbgWrData;
		end
		// Map read data is zero for writes and errors.
		if (s1Valid) begin
			capData <= (s1Map && !s1Wr) ? i_mapRdData : '0;
		end
	end

	assign dbgMemEn = s1Valid & ~s1Map & ~s1Err;

	//--------------------------------------------------------------------------
	// Bus drive.
	//--------------------------------------------------------------------------

	// Boot owns the SRAM until booted.
	assign o_memAddr    = i_isBooted ? s1Addr : i_bootAddr;
	assign o_memDataOut = i_isBooted ? s1Data : i_bootData;
	assign o_memEn      = i_isBooted ? dbgMemEn : i_bootEn;
	assign o_memWr      = i_isBooted ? (dbgMemEn & s1Wr) : i_bootEn;

	assign o_mapAddrSel = (s1Addr == MAP_STAT_ADDR);
	assign o_mapWrEn    = s1Valid & s1Map & s1Wr & (s1Addr == MAP_CTRL_ADDR);
	assign o_mapWrData  = s1Data;

	assign o_dbgRdData  = memRdQ ? i_memDataIn : capData;
	assign o_dbgAck     = ackQ;
	assign o_dbgErr     = errQ;

endmodule

//--- MappedRegisters.sv
// Mapped registers: writable control word and read-only status word.
`timescale 1ns/1ps

module MappedRegisters (
	input  logic                       i_sysClk,
	input  logic                       i_rstN,
	input  logic                       i_addrSel,
	input  logic                       i_wrEn,
	input  logic [UProcPkg::MEM_W-1:0] i_wrData,
	input  logic                       i_isBooted,
	input  logic                       i_isPaused,
	input  logic [7:0]                 i_wordCount,
	output logic [UProcPkg::MEM_W-1:0] o_rdData,
	output logic                       o_pauseReq
);
	import UProcPkg::*;

	// Control word, written raw.
	ctrlWord_u        ctrlReg;
	// Status word, built from state.
	logic [MEM_W-1:0] statWord;

	//--------------------------------------------------------------------------
	// Control register.
	//--------------------------------------------------------------------------

	// Select low is control; status is read only.
	always_ff @(posedge i_sysClk or negedge i_rstN) begin
		if (!i_rstN) begin
			ctrlReg.raw <= '0;
		end else if (i_wrEn && !i_addrSel) begin
			ctrlReg.raw <= i_wrData;
		end
	end

	// Pause bit feeds the pause network.
	assign o_pauseReq = ctrlReg.f.pauseReq;

	//--------------------------------------------------------------------------
	// Status register.
	//--------------------------------------------------------------------------

	always_comb begin
		statWord                                = '0;
		statWord[STAT_BOOTED_BIT]               = i_isBooted;
		statWord[STAT_PAUSED_BIT]               = i_isPaused;
		// Low byte of the image size.
		statWord[STAT_COUNT_MSB:STAT_COUNT_LSB] = i_wordCount;
	end

	// Read mux.
	assign o_rdData = i_addrSel ? statWord : ctrlReg.raw;

endmodule

//--- UProcBoot.sv
// Top level of the boot subsystem: bootloader, memory controller, mapped registers, pause.
`timescale 1ns/1ps

module UProcBoot #(
	parameter int SPI_HALF_DIV = 2
) (
	// SPI EEPROM.
	input  logic                       i_spiMISO,
	output logic                       o_spiCLK,
	output logic                       o_spiMOSI,
	output logic                       o_spiCSn,
	// Runtime SRAM.
	output logic [UProcPkg::MEM_W-1:0] o_memAddr,
	output logic [UProcPkg::MEM_W-1:0] o_memDataOut,
	input  logic [UProcPkg::MEM_W-1:0] i_memDataIn,
	output logic                       o_memWr,
	output logic                       o_memEn,
	// Debug port.
	input  logic                       i_dbgEn,
	input  logic                       i_dbgWr,
	input  logic [UProcPkg::MEM_W-1:0] i_dbgAddr,
	input  logic [UProcPkg::MEM_W-1:0] i_dbgWrData,
	output logic [UProcPkg::MEM_W-1:0] o_dbgRdData,
	output logic                       o_dbgAck,
	output logic                       o_dbgErr,
	// State pins.
	input  logic                       i_smDoPause,
	output logic                       o_smIsBooted,
	output logic                       o_smIsPaused,
	// System.
	input  logic                       i_sysClk,
	input  logic                       i_arstN
);
	import UProcPkg::*;

	//--------------------------------------------------------------------------
	// Internal nets.
	//--------------------------------------------------------------------------

	logic             sysRstN;
	logic             nowBooted;
	logic             isPaused;
	logic             pauseReq;
	logic [7:0]       wordCount;
	// Boot write bus.
	logic [MEM_W-1:0] bootMemAddr;
	logic [MEM_W-1:0] bootMemData;
	logic             bootMemEn;
	// Mapped register bus.
	logic             mapAddrSel;
	logic             mapWrEn;
	logic [MEM_W-1:0] mapWrData;
	logic [MEM_W-1:0] mapRdData;

	//--------------------------------------------------------------------------
	// Blocks.
	//--------------------------------------------------------------------------

	// Reset, pause pin and pause network.
	SysControl SYS_CTRL (
		.i_sysClk(i_sysClk),
		.i_arstN(i_arstN),
		.i_smDoPause(i_smDoPause),
		.i_pauseReq(pauseReq),
		.i_nowBooted(nowBooted),
		.o_rstN(sysRstN),
		.o_isPaused(isPaused)
	);

	// Image copy from EEPROM.
	BootImage #(
		.SPI_HALF_DIV(SPI_HALF_DIV)
	) BOOT_IMAGE (
		.i_sysClk(i_sysClk),
		.i_rstN(sysRstN),
		.i_spiMISO(i_spiMISO),
		.o_spiCLK(o_spiCLK),
		.o_spiMOSI(o_spiMOSI),
		.o_spiCSn(o_spiCSn),
		.o_memAddr(bootMemAddr),
		.o_memDataOut(bootMemData),
		.o_memEn(bootMemEn),
		.o_nowBooted(nowBooted),
		.o_wordCount(wordCount)
	);

	// SRAM arbitration and debug access.
	MemController MEM_CTRL (
		.i_sysClk(i_sysClk),
		.i_rstN(sysRstN),
		.i_bootAddr(bootMemAddr),
		.i_bootData(bootMemData),
		.i_bootEn(bootMemEn),
		.i_dbgEn(i_dbgEn),
		.i_dbgWr(i_dbgWr),
		.i_dbgAddr(i_dbgAddr),
		.i_dbgWrData(i_dbgWrData),
		.i_isBooted(nowBooted),
		.i_isPaused(isPaused),
		.i_mapRdData(mapRdData),
		.i_memDataIn(i_memDataIn),
		.o_dbgRdData(o_dbgRdData),
		.o_dbgAck(o_dbgAck),
		.o_dbgErr(o_dbgErr),
		.o_memAddr(o_memAddr),
		.o_memDataOut(o_memDataOut),
		.o_memWr(o_memWr),
		.o_memEn(o_memEn),
		.o_mapAddrSel(mapAddrSel),
		.o_mapWrEn(mapWrEn),
		.o_mapWrData(mapWrData)
	);

	// Control and status words.
	MappedRegisters MAPPED_REGS (
		.i_sysClk(i_sysClk),
		.i_rstN(sysRstN),
		.i_addrSel(mapAddrSel),
		.i_wrEn(mapWrEn),
		.i_wrData(mapWrData),
		.i_isBooted(nowBooted),
		.i_isPaused(isPaused),
		.i_wordCount(wordCount),
		.o_rdData(mapRdData),
		.o_pauseReq(pauseReq)
	);

	// State indicator pins.
	assign o_smIsBooted = nowBooted;
	assign o_smIsPaused = isPaused;

endmodule

//--- TbClock.sv
// Testbench clock and reset generator for the boot subsystem.
`timescale 1ns/1ps

module TbClock #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clk,
	output logic o_arstN
);

	// Free-running system clock.
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// Reset held for a fixed number of cycles, released on a falling edge.
	initial begin
		o_arstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_arstN = 1'b1;
	end

endmodule

//--- TbModels.sv
// Behavioral SPI EEPROM and synchronous SRAM models for the boot subsystem testbench.
`timescale 1ns/1ps

//----------------------------------------------------------------------------
// SPI EEPROM, mode 0, streams words from its array after command and address.
//----------------------------------------------------------------------------
module SpiEeprom (
	input  logic i_sck,
	input  logic i_csN,
	input  logic i_mosi,
	output logic o_miso
);

	// Word 0 holds the count, the image follows.
	logic [15:0] mem [0:63];
	// Command byte and address as received.
	logic [23:0] cmdAddr = '0;
	logic [5:0]  inCount = '0;
	logic [9:0]  outIdx  = '0;
	logic        miso    = 1'b0;

	// Header bits sampled on the rising edge.
	always @(posedge i_sck) begin
		if (!i_csN && inCount < 6'd24) begin
			cmdAddr <= {cmdAddr[22:0], i_mosi};
			inCount <= inCount + 6'd1;
		end
	end

	// Data moves on the falling edge, MSB first.
	always @(negedge i_sck) begin
		if (!i_csN && inCount == 6'd24) begin
			miso   <= mem[outIdx[9:4]][4'd15 - outIdx[3:0]];
			outIdx <= outIdx + 10'd1;
		end
	end

	assign o_miso = miso;

endmodule

//----------------------------------------------------------------------------
// SRAM, read data one cycle after the enable.
//----------------------------------------------------------------------------
module SyncSram #(
	parameter int AW = 6
) (
	input  logic        i_clk,
	input  logic        i_en,
	input  logic        i_wr,
	input  logic [15:0] i_addr,
	input  logic [15:0] i_din,
	output logic [15:0] o_dout
);

	logic [15:0] mem [0:(1 << AW) - 1];
	logic [15:0] dout = '0;

	// Power-up contents, distinct per address.
	initial begin
		for (int a = 0; a < (1 << AW); a++) begin
			mem[a[AW-1:0]] = 16'hA000 ^ 16'(a * 257);
		end
	end

	always @(posedge i_clk) begin
		if (i_en) begin
			if (i_wr) begin
				mem[i_addr[AW-1:0]] <= i_din;
			end else begin
				dout <= mem[i_addr[AW-1:0]];
			end
		end
	end

	assign o_dout = dout;

endmodule

//--- UProcBoot_properties.sv
// Bound checks on the debug handshake, SRAM strobes and boot/pause state of the boot subsystem.
`timescale 1ns/1ps

module UProcBootProperties (
	input logic i_sysClk,
	input logic i_arstN,
	input logic i_dbgAck,
	input logic i_dbgErr,
	input logic i_memWr,
	input logic i_memEn,
	input logic i_smIsBooted,
	input logic i_smIsPaused,
	input logic i_spiCSn
);

	// Ack is a single-cycle pulse.
	ackPulse: assert property (@(posedge i_sysClk) disable iff (!i_arstN)
		i_dbgAck |=> !i_dbgAck)
		else $error("Debug ack stayed high for more than one cycle.");

	// Error only comes with an ack.
	errWithAck: assert property (@(posedge i_sysClk) disable iff (!i_arstN)
		i_dbgErr |-> i_dbgAck)
		else $error("Debug error flagged without an ack.");

	// A write strobe always enables the SRAM.
	wrNeedsEn: assert property (@(posedge i_sysClk) disable iff (!i_arstN)
		i_memWr |-> i_memEn)
		else $error("SRAM write without SRAM enable.");

	// Paused only once booted.
	pausedNeedsBoot: assert property (@(posedge i_sysClk) disable iff (!i_arstN)
		i_smIsPaused |-> i_smIsBooted)
		else $error("Paused state reported before boot completed.");

	// EEPROM stays deselected after boot.
	csHighAfterBoot: assert property (@(posedge i_sysClk) disable iff (!i_arstN)
		i_smIsBooted |-> i_spiCSn)
		else $error("SPI chip select low after boot completed.");

endmodule

//--- tb_UProcBoot.sv
// Testbench for the boot subsystem covering image boot, debug access, mapped registers and pause.
`timescale 1ns/1ps

module tb_UProcBoot;
	import UProcPkg::*;

	localparam int          SPI_HALF_DIV     = 2;
	localparam int          IMG_WORDS        = 12;
	localparam logic [31:0] SEED             = 32'h97a97453;
	localparam int          ACK_LATENCY      = 2;
	localparam int          ACK_WAIT_LIMIT   = 16;
	localparam int          PAUSE_WAIT_LIMIT = 16;
	// Boot takes near IMG_WORDS * 16 * 2 * SPI_HALF_DIV + 200 cycles and the tests a few hundred.
	localparam int          TIMEOUT_CYCLES   = 4000;

	logic        sysClk;
	logic        arstN;
	logic        spiCLK;
	logic        spiMOSI;
	logic        spiCSn;
	logic        spiMISO;
	logic [15:0] memAddr;
	logic [15:0] memDataOut;
	logic [15:0] memDataIn;
	logic        memWr;
	logic        memEn;
	logic        dbgEn;
	logic        dbgWr;
	logic [15:0] dbgAddr;
	logic [15:0] dbgWrData;
	logic [15:0] dbgRdData;
	logic        dbgAck;
	logic        dbgErr;
	logic        smDoPause;
	logic        smIsBooted;
	logic        smIsPaused;

	// Image words and random state.
	logic [15:0] img [$];
	logic [31:0] rngState;
	int          cycleCount = 0;

	//------------------------------------------------------------------------
	// Clock, DUT, memory models.
	//------------------------------------------------------------------------

	TbClock #(.PERIOD_NS(100), .RESET_CYCLES(4)) clockGen (
		.o_clk(sysClk),
		.o_arstN(arstN)
	);

	UProcBoot #(.SPI_HALF_DIV(SPI_HALF_DIV)) UProcBoot_inst (
		.i_spiMISO(spiMISO),
		.o_spiCLK(spiCLK),
		.o_spiMOSI(spiMOSI),
		.o_spiCSn(spiCSn),
		.o_memAddr(memAddr),
		.o_memDataOut(memDataOut),
		.i_memDataIn(memDataIn),
		.o_memWr(memWr),
		.o_memEn(memEn),
		.i_dbgEn(dbgEn),
		.i_dbgWr(dbgWr),
		.i_dbgAddr(dbgAddr),
		.i_dbgWrData(dbgWrData),
		.o_dbgRdData(dbgRdData),
		.o_dbgAck(dbgAck),
		.o_dbgErr(dbgErr),
		.i_smDoPause(smDoPause),
		.o_smIsBooted(smIsBooted),
		.o_smIsPaused(smIsPaused),
		.i_sysClk(sysClk),
		.i_arstN(arstN)
	);

	SpiEeprom eeprom (
		.i_sck(spiCLK),
		.i_csN(spiCSn),
		.i_mosi(spiMOSI),
		.o_miso(spiMISO)
	);

	SyncSram #(.AW(6)) sram (
		.i_clk(sysClk),
		.i_en(memEn),
		.i_wr(memWr),
		.i_addr(memAddr),
		.i_din(memDataOut),
		.o_dout(memDataIn)
	);

	bind UProcBoot UProcBootProperties UProcBootProperties_inst (
		.i_sysClk(i_sysClk),
		.i_arstN(i_arstN),
		.i_dbgAck(o_dbgAck),
		.i_dbgErr(o_dbgErr),
		.i_memWr(o_memWr),
		.i_memEn(o_memEn),
		.i_smIsBooted(o_smIsBooted),
		.i_smIsPaused(o_smIsPaused),
		.i_spiCSn(o_spiCSn)
	);

	//------------------------------------------------------------------------
	// Failure reporting and helpers.
	//------------------------------------------------------------------------

	task automatic stopRun();
		$display("TB FAILED");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		$display("[ERROR] %s exp=%h got=%h", name, exp, got);
		stopRun();
	endtask

	task automatic reportProblem(input string msg);
		$display("%s", msg);
		stopRun();
	endtask

	task automatic checkValue(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		assert (got == exp) else reportMismatch(name, exp, got);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Status word has the count byte on top, paused in bit 1 and booted in bit 0.
	function automatic logic [15:0] expectStatus(input logic booted, input logic paused);
		return {8'(IMG_WORDS), 6'b0, paused, booted};
	endfunction

	// Holds one debug request until the ack and drops it for one cycle after.
	task automatic dbgAccess(input logic wr, input logic [15:0] addr,
			input logic [15:0] wdata, output logic [15:0] rdata, output logic err);
		int waited;
		dbgEn     = 1'b1;
		dbgWr     = wr;
		dbgAddr   = addr;
		dbgWrData = wdata;
		waited    = 0;
		do begin
			@(negedge sysClk);
			waited++;
		end while (!dbgAck && waited < ACK_WAIT_LIMIT);
		assert (dbgAck) else reportProblem($sformatf(
			"No debug ack for address %h within %0d cycles.", addr, ACK_WAIT_LIMIT));
		checkValue("o_dbgAck latency", 32'(ACK_LATENCY), 32'(waited));
		rdata = dbgRdData;
		err   = dbgErr;
		dbgEn = 1'b0;
		dbgWr = 1'b0;
		@(negedge sysClk);
	endtask

	task automatic waitPaused(input logic level, input string what);
		int waited;
		waited = 0;
		while (smIsPaused != level && waited < PAUSE_WAIT_LIMIT) begin
			@(negedge sysClk);
			waited++;
		end
		assert (smIsPaused == level) else reportProblem(what);
	endtask

	//------------------------------------------------------------------------
	// Directed tests.
	//------------------------------------------------------------------------

	task automatic testResetState();
		repeat (2) @(negedge sysClk);
		checkValue("o_spiCSn", 32'd1, 32'(spiCSn));
		checkValue("o_memEn", 32'd0, 32'(memEn));
		checkValue("o_memWr", 32'd0, 32'(memWr));
		checkValue("o_dbgAck", 32'd0, 32'(dbgAck));
		checkValue("o_dbgErr", 32'd0, 32'(dbgErr));
		checkValue("o_smIsBooted", 32'd0, 32'(smIsBooted));
		checkValue("o_smIsPaused", 32'd0, 32'(smIsPaused));
		// Boot runs on its own until the booted flag rises.
		while (!smIsBooted) @(negedge sysClk);
		checkValue("o_spiCSn", 32'd1, 32'(spiCSn));
		checkValue("spi command", 32'({SPI_READ_CMD, 16'h0000}), 32'(eeprom.cmdAddr));
		for (int k = 0; k < IMG_WORDS; k++) begin
			checkValue($sformatf("sram word %0d", k), 32'(img[k]), 32'(sram.mem[6'(k)]));
		end
	endtask

	task automatic testStatusRead();
		logic [15:0] rd;
		logic        err;
		dbgAccess(1'b0, MAP_STAT_ADDR, 16'h0000, rd, err);
		checkValue("o_dbgRdData", 32'(expectStatus(1'b1, 1'b0)), 32'(rd));
		checkValue("o_dbgErr", 32'd0, 32'(err));
		// SRAM is off limits while running.
		dbgAccess(1'b0, 16'h0003, 16'h0000, rd, err);
		checkValue("o_dbgErr", 32'd1, 32'(err));
		checkValue("o_dbgRdData", 32'd0, 32'(rd));
	endtask

	task automatic testCtrlPause();
		logic [15:0] rd;
		logic        err;
		dbgAccess(1'b1, MAP_CTRL_ADDR, {8'hA5, 7'd0, 1'b1}, rd, err);
		checkValue("o_dbgErr", 32'd0, 32'(err));
		waitPaused(1'b1, "Pause did not follow the control pause bit.");
		dbgAccess(1'b0, MAP_CTRL_ADDR, 16'h0000, rd, err);
		checkValue("o_dbgRdData", 32'({8'hA5, 7'd0, 1'b1}), 32'(rd));
		dbgAccess(1'b0, MAP_STAT_ADDR, 16'h0000, rd, err);
		checkValue("o_dbgRdData", 32'(expectStatus(1'b1, 1'b1)), 32'(rd));
	endtask

	task automatic testDebugSram();
		logic [15:0] rd;
		logic [15:0] wval;
		logic        err;
		for (int k = 0; k < IMG_WORDS; k++) begin
			dbgAccess(1'b0, 16'(k), 16'h0000, rd, err);
			checkValue("o_dbgErr", 32'd0, 32'(err));
			checkValue($sformatf("o_dbgRdData word %0d", k), 32'(img[k]), 32'(rd));
		end
		rngState = xorshift32(rngState);
		wval     = rngState[15:0];
		dbgAccess(1'b1, 16'd20, wval, rd, err);
		checkValue("o_dbgErr", 32'd0, 32'(err));
		dbgAccess(1'b0, 16'd20, 16'h0000, rd, err);
		checkValue("o_dbgRdData word 20", 32'(wval), 32'(rd));
	endtask

	task automatic testPausePin();
		logic [15:0] rd;
		logic        err;
		smDoPause = 1'b1;
		repeat (4) @(negedge sysClk);
		dbgAccess(1'b1, MAP_CTRL_ADDR, {8'hA5, 7'd0, 1'b0}, rd, err);
		// Pin alone keeps the chip paused.
		repeat (6) begin
			@(negedge sysClk);
			checkValue("o_smIsPaused", 32'd1, 32'(smIsPaused));
		end
		smDoPause = 1'b0;
		waitPaused(1'b0, "Pause did not drop after the pause pin was released.");
		dbgAccess(1'b0, 16'h0000, 16'h0000, rd, err);
		checkValue("o_dbgErr", 32'd1, 32'(err));
		checkValue("o_dbgRdData", 32'd0, 32'(rd));
	endtask

	//------------------------------------------------------------------------
	// Timeout and main sequence.
	//------------------------------------------------------------------------

	always @(posedge sysClk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			reportProblem($sformatf("Timeout after %0d cycles.", TIMEOUT_CYCLES));
		end
	end

	initial begin
		dbgEn     = 1'b0;
		dbgWr     = 1'b0;
		dbgAddr   = 16'h0000;
		dbgWrData = 16'h0000;
		smDoPause = 1'b0;
		// Image words come from the fixed seed.
		rngState = SEED;
		for (int k = 0; k < IMG_WORDS; k++) begin
			rngState = xorshift32(rngState);
			img.push_back(rngState[15:0]);
		end
		// EEPROM holds the count first and the image words after it.
		eeprom.mem[0] = 16'(IMG_WORDS);
		for (int k = 0; k < IMG_WORDS; k++) begin
			eeprom.mem[6'(k + 1)] = img[k];
		end
		testResetState();
		testStatusRead();
		testCtrlPause();
		testDebugSram();
		testPausePin();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- sim.f
UProcPkg.sv
SysControl.sv
BootImage.sv
MemController.sv
MappedRegisters.sv
UProcBoot.sv
TbClock.sv
TbModels.sv
UProcBoot_properties.sv
tb_UProcBoot.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_UProcBoot
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
